// ==== include/emu_defines.svh ====
`ifndef EMU_DEFINES_SVH
`define EMU_DEFINES_SVH

// Register bus
`define EMU_ADDR_W      12
`define EMU_DATA_W      32

// Scan word and trigger widths
`define EMU_SCAN_W      64
`define EMU_TRIG_W      32

// Chain lengths in scan words
`define EMU_FF_WORDS    4
`define EMU_RAM_WORDS   3

// Run control registers
`define EMU_STAT        12'h000
`define EMU_TRIG_STAT   12'h004
`define EMU_CYCLE_LO    12'h008
`define EMU_CYCLE_HI    12'h00C
`define EMU_STEP        12'h010

// Checkpoint registers
`define EMU_CKPT_SIZE   12'h014
`define EMU_CKPT_STAT   12'h018
`define EMU_CKPT_CTRL   12'h01C

`endif

// ==== rtl/emu_pkg.sv ====
`default_nettype none

package emu_pkg;

    // Scan sequencer phase
    typedef enum logic [1:0] {
        CKPT_IDLE = 2'd0,
        CKPT_FF   = 2'd1,
        CKPT_RAM  = 2'd2
    } ckpt_state_t;

    // Save streams the chains out, load streams them in
    typedef enum logic {
        CKPT_SAVE = 1'b0,
        CKPT_LOAD = 1'b1
    } ckpt_dir_t;

    // AXI response codes in use
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_SLVERR = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire

// ==== rtl/emu_csr_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_csr_slave
    import emu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,

    input  wire                         s_axil_awvalid,
    output logic                        s_axil_awready,
    input  wire [`EMU_ADDR_W-1:0]       s_axil_awaddr,
    input  wire                         s_axil_wvalid,
    output logic                        s_axil_wready,
    input  wire [`EMU_DATA_W-1:0]       s_axil_wdata,
    input  wire [`EMU_DATA_W/8-1:0]     s_axil_wstrb,
    output logic                        s_axil_bvalid,
    input  wire                         s_axil_bready,
    output axil_resp_t                  s_axil_bresp,
    input  wire                         s_axil_arvalid,
    output logic                        s_axil_arready,
    input  wire [`EMU_ADDR_W-1:0]       s_axil_araddr,
    output logic                        s_axil_rvalid,
    input  wire                         s_axil_rready,
    output logic [`EMU_DATA_W-1:0]      s_axil_rdata,
    output axil_resp_t                  s_axil_rresp,

    output logic                        wr_en,
    output logic [`EMU_ADDR_W-1:0]      wr_addr,
    output logic [`EMU_DATA_W-1:0]      wr_data,
    output logic [`EMU_ADDR_W-1:0]      rd_addr,
    input  wire [`EMU_DATA_W-1:0]       rd_data_run,
    input  wire [`EMU_DATA_W-1:0]       rd_data_ckpt
);

    logic                       aw_held;
    logic                       w_held;
    logic                       wr_err;
    logic                       b_pend;
    logic [`EMU_ADDR_W-1:0]     aw_addr;
    logic [`EMU_DATA_W-1:0]     w_data;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       commit;

    logic                       ar_held;
    logic                       r_pend;
    logic [`EMU_ADDR_W-1:0]     ar_addr;
    logic [`EMU_DATA_W-1:0]     r_data;
    logic                       ar_fire;
    logic                       r_fire;
    logic                       r_load;

    assign aw_fire = s_axil_awvalid && s_axil_awready;
    assign w_fire  = s_axil_wvalid && s_axil_wready;
    assign commit  = aw_held && w_held;

    // Write path, address and data may arrive in either order
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            wr_err  <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_held <= 1'b1;
            end
            if (w_fire) begin
                w_held <= 1'b1;
                wr_err <= s_axil_wstrb != '1;
            end
            if (commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_pend  <= 1'b1;
            end
            if (s_axil_bvalid && s_axil_bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr <= s_axil_awaddr;
        end
        if (w_fire) begin
            w_data <= s_axil_wdata;
        end
    end

    assign s_axil_awready = !aw_held && !b_pend;
    assign s_axil_wready  = !w_held;
    assign s_axil_bvalid  = b_pend;
    assign s_axil_bresp   = wr_err ? AXIL_SLVERR : AXIL_OKAY;

    // Partial strobes never reach the registers
    assign wr_en   = commit && !wr_err;
    assign wr_addr = aw_addr;
    assign wr_data = w_data;

    assign ar_fire = s_axil_arvalid && s_axil_arready;
    assign r_fire  = s_axil_rvalid && s_axil_rready;
    assign r_load  = ar_held && !r_pend;

    // Read path
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            r_pend  <= 1'b0;
        end else begin
            if (ar_fire) begin
                ar_held <= 1'b1;
            end
            if (r_load) begin
                r_pend <= 1'b1;
            end
            if (r_fire) begin
                ar_held <= 1'b0;
                r_pend  <= 1'b0;
            end
        end
    end

    // Owners return 0 outside their own range
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            ar_addr <= s_axil_araddr;
        end
        if (r_load) begin
            r_data <= rd_data_run | rd_data_ckpt;
        end
    end

    assign rd_addr        = ar_addr;
    assign s_axil_arready = !ar_held;
    assign s_axil_rvalid  = r_pend;
    assign s_axil_rdata   = r_data;
    assign s_axil_rresp   = AXIL_OKAY;

endmodule

`default_nettype wire

// ==== rtl/emu_run_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_run_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire [`EMU_ADDR_W-1:0]       wr_addr,
    input  wire [`EMU_DATA_W-1:0]       wr_data,
    input  wire [`EMU_ADDR_W-1:0]       rd_addr,
    input  wire [`EMU_TRIG_W-1:0]       dut_trig,
    output logic [`EMU_DATA_W-1:0]      rd_data_run,
    output logic                        pause,
    output logic                        dut_rst
);

    logic                           step_trig_r;
    logic [`EMU_TRIG_W-1:0]         trig_stat;
    logic [2*`EMU_DATA_W-1:0]       cycle;
    logic [`EMU_DATA_W-1:0]         step;
    logic [`EMU_DATA_W-1:0]         step_next;
    logic                           step_hit;
    logic                           trigger;

    // Step count runs down only while the DUT runs
    always_comb begin
        if (pause || step == '0) begin
            step_next = step;
        end else begin
            step_next = step - 1'b1;
        end
    end

    assign step_hit = step != '0 && step_next == '0;
    assign trigger  = step_hit || |dut_trig;

    // STAT, a trigger wins over a register write
    always_ff @(posedge clk) begin
        if (rst) begin
            pause       <= 1'b1;
            dut_rst     <= 1'b1;
            step_trig_r <= 1'b0;
        end else if (trigger) begin
            pause       <= 1'b1;
            step_trig_r <= step_hit;
        end else if (wr_en && wr_addr == `EMU_STAT) begin
            pause   <= wr_data[0];
            dut_rst <= wr_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_stat <= '0;
        end else if (trigger) begin
            trig_stat <= dut_trig;
        end
    end

    // Cycle counter, writable only while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!pause) begin
            cycle <= cycle + 1'b1;
        end else if (wr_en) begin
            if (wr_addr == `EMU_CYCLE_LO) begin
                cycle[`EMU_DATA_W-1:0] <= wr_data;
            end
            if (wr_addr == `EMU_CYCLE_HI) begin
                cycle[2*`EMU_DATA_W-1:`EMU_DATA_W] <= wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (wr_en && wr_addr == `EMU_STEP) begin
            step <= wr_data;
        end else begin
            step <= step_next;
        end
    end

    always_comb begin
        case (rd_addr)
            `EMU_STAT:      rd_data_run = {step_trig_r, {(`EMU_DATA_W-3){1'b0}}, dut_rst, pause};
            `EMU_TRIG_STAT: rd_data_run = trig_stat;
            `EMU_CYCLE_LO:  rd_data_run = cycle[`EMU_DATA_W-1:0];
            `EMU_CYCLE_HI:  rd_data_run = cycle[2*`EMU_DATA_W-1:`EMU_DATA_W];
            `EMU_STEP:      rd_data_run = step;
            default:        rd_data_run = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/emu_ckpt_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_ckpt_seq
    import emu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  wire [`EMU_ADDR_W-1:0]       wr_addr,
    input  wire [`EMU_DATA_W-1:0]       wr_data,
    input  wire [`EMU_ADDR_W-1:0]       rd_addr,
    output logic [`EMU_DATA_W-1:0]      rd_data_ckpt,
    input  wire                         pause,

    output logic                        ff_se,
    output logic [`EMU_SCAN_W-1:0]      ff_sdi,
    input  wire [`EMU_SCAN_W-1:0]       ff_sdo,
    output logic                        ram_se,
    output ckpt_dir_t                   ram_sd,
    output logic [`EMU_SCAN_W-1:0]      ram_sdi,
    input  wire [`EMU_SCAN_W-1:0]       ram_sdo,
    output logic                        ff_clk_en,
    output logic                        ram_clk_en,

    output logic [`EMU_SCAN_W-1:0]      ckpt_out_data,
    output logic                        ckpt_out_valid,
    output logic                        ckpt_out_last,
    input  wire                         ckpt_out_ready,
    input  wire [`EMU_SCAN_W-1:0]       ckpt_in_data,
    input  wire                         ckpt_in_valid,
    output logic                        ckpt_in_ready
);

    localparam int MAX_WORDS = (`EMU_FF_WORDS > `EMU_RAM_WORDS) ?
                               `EMU_FF_WORDS : `EMU_RAM_WORDS;
    localparam int CNT_W     = $clog2(MAX_WORDS + 1);

    localparam logic [CNT_W-1:0]       FF_LAST    = CNT_W'(`EMU_FF_WORDS - 1);
    localparam logic [CNT_W-1:0]       RAM_LAST   = CNT_W'(`EMU_RAM_WORDS - 1);
    localparam logic [`EMU_DATA_W-1:0] CKPT_BYTES = 8 * (`EMU_FF_WORDS + `EMU_RAM_WORDS);

    ckpt_state_t                state;
    ckpt_dir_t                  dir;
    logic [CNT_W-1:0]           word_cnt;
    logic                       running;
    logic                       ctrl_wr;
    logic                       stall;
    logic                       xfer;
    logic                       phase_last;

    assign running    = state != CKPT_IDLE;
    assign ctrl_wr    = wr_en && wr_addr == `EMU_CKPT_CTRL && !running;
    assign ff_se      = state == CKPT_FF;
    assign ram_se     = state == CKPT_RAM;
    assign phase_last = ff_se ? word_cnt == FF_LAST : word_cnt == RAM_LAST;

    // Stream side not ready, freeze the scan and the DUT clocks
    assign stall = running && (dir == CKPT_LOAD ? !ckpt_in_valid : !ckpt_out_ready);
    assign xfer  = running && !stall;

    // Flip-flop chain first, then memory chain
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= CKPT_IDLE;
            dir      <= CKPT_SAVE;
            word_cnt <= '0;
        end else if (ctrl_wr) begin
            dir <= ckpt_dir_t'(wr_data[1]);
            if (wr_data[0]) begin
                state <= CKPT_FF;
            end
        end else if (xfer) begin
            if (phase_last) begin
                word_cnt <= '0;
                state    <= ff_se ? CKPT_RAM : CKPT_IDLE;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // Save recirculates the FF chain so the DUT state survives
    assign ff_sdi  = (dir == CKPT_LOAD) ? ckpt_in_data : ff_sdo;
    assign ram_sdi = ckpt_in_data;
    assign ram_sd  = dir;

    assign ckpt_out_valid = running && dir == CKPT_SAVE;
    assign ckpt_out_data  = ff_se ? ff_sdo : ram_sdo;
    assign ckpt_out_last  = ckpt_out_valid && ram_se && phase_last;
    assign ckpt_in_ready  = running && dir == CKPT_LOAD;

    assign ff_clk_en  = !stall && (!pause || ff_se);
    assign ram_clk_en = !stall && (!pause || ram_se);

    // Start bit self clears and reads back 0
    always_comb begin
        case (rd_addr)
            `EMU_CKPT_SIZE: rd_data_ckpt = CKPT_BYTES;
            `EMU_CKPT_STAT: rd_data_ckpt = {{(`EMU_DATA_W-1){1'b0}}, running};
            `EMU_CKPT_CTRL: rd_data_ckpt = {{(`EMU_DATA_W-2){1'b0}}, dir, 1'b0};
            default:        rd_data_ckpt = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/emu_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_controller
    import emu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,

    // Register access
    input  wire                         s_axil_awvalid,
    output logic                        s_axil_awready,
    input  wire [`EMU_ADDR_W-1:0]       s_axil_awaddr,
    input  wire                         s_axil_wvalid,
    output logic                        s_axil_wready,
    input  wire [`EMU_DATA_W-1:0]       s_axil_wdata,
    input  wire [`EMU_DATA_W/8-1:0]     s_axil_wstrb,
    output logic                        s_axil_bvalid,
    input  wire                         s_axil_bready,
    output axil_resp_t                  s_axil_bresp,
    input  wire                         s_axil_arvalid,
    output logic                        s_axil_arready,
    input  wire [`EMU_ADDR_W-1:0]       s_axil_araddr,
    output logic                        s_axil_rvalid,
    input  wire                         s_axil_rready,
    output logic [`EMU_DATA_W-1:0]      s_axil_rdata,
    output axil_resp_t                  s_axil_rresp,

    // DUT control and scan chains
    output logic                        dut_rst,
    input  wire [`EMU_TRIG_W-1:0]       dut_trig,
    output logic                        ff_clk_en,
    output logic                        ram_clk_en,
    output logic                        ff_se,
    output logic [`EMU_SCAN_W-1:0]      ff_sdi,
    input  wire [`EMU_SCAN_W-1:0]       ff_sdo,
    output logic                        ram_se,
    output ckpt_dir_t                   ram_sd,
    output logic [`EMU_SCAN_W-1:0]      ram_sdi,
    input  wire [`EMU_SCAN_W-1:0]       ram_sdo,

    // Checkpoint streams
    output logic [`EMU_SCAN_W-1:0]      ckpt_out_data,
    output logic                        ckpt_out_valid,
    output logic                        ckpt_out_last,
    input  wire                         ckpt_out_ready,
    input  wire [`EMU_SCAN_W-1:0]       ckpt_in_data,
    input  wire                         ckpt_in_valid,
    output logic                        ckpt_in_ready
);

    // Internal register bus
    logic                       wr_en;
    logic [`EMU_ADDR_W-1:0]     wr_addr;
    logic [`EMU_DATA_W-1:0]     wr_data;
    logic [`EMU_ADDR_W-1:0]     rd_addr;
    logic [`EMU_DATA_W-1:0]     rd_data_run;
    logic [`EMU_DATA_W-1:0]     rd_data_ckpt;

    logic                       pause;

    emu_csr_slave u_csr_slave (.*);

    emu_run_ctrl u_run_ctrl (.*);

    emu_ckpt_seq u_ckpt_seq (.*);

endmodule

`default_nettype wire

// ==== bench/emu_chain_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_chain_model
    import emu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         ff_clk_en,
    input  wire                         ff_se,
    input  wire [`EMU_SCAN_W-1:0]       ff_sdi,
    output logic [`EMU_SCAN_W-1:0]      ff_sdo,
    input  wire                         ram_clk_en,
    input  wire                         ram_se,
    input  wire                         ram_sd,
    input  wire [`EMU_SCAN_W-1:0]       ram_sdi,
    output logic [`EMU_SCAN_W-1:0]      ram_sdo,
    input  wire [`EMU_TRIG_W-1:0]       trig_in,
    output logic [`EMU_TRIG_W-1:0]      dut_trig
);

    logic [`EMU_SCAN_W-1:0]     ff_words [`EMU_FF_WORDS];
    logic [`EMU_SCAN_W-1:0]     ram_words [`EMU_RAM_WORDS];

    assign ff_sdo   = ff_words[0];
    assign ram_sdo  = ram_words[0];
    assign dut_trig = trig_in;

    // Head word leaves, new word enters at the tail
    // Outside a scan the DUT logic just counts up
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EMU_FF_WORDS; i++) begin
                ff_words[i] <= '0;
            end
        end else if (ff_clk_en && ff_se) begin
            for (int i = 0; i < `EMU_FF_WORDS - 1; i++) begin
                ff_words[i] <= ff_words[i+1];
            end
            ff_words[`EMU_FF_WORDS-1] <= ff_sdi;
        end else if (ff_clk_en) begin
            for (int i = 0; i < `EMU_FF_WORDS; i++) begin
                ff_words[i] <= ff_words[i] + 1'b1;
            end
        end
    end

    // Memory read-out recirculates, only a load writes new words
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EMU_RAM_WORDS; i++) begin
                ram_words[i] <= '0;
            end
        end else if (ram_clk_en && ram_se) begin
            for (int i = 0; i < `EMU_RAM_WORDS - 1; i++) begin
                ram_words[i] <= ram_words[i+1];
            end
            ram_words[`EMU_RAM_WORDS-1] <= (ram_sd == CKPT_LOAD) ? ram_sdi : ram_words[0];
        end
    end

endmodule

`default_nettype wire

// ==== bench/emu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "emu_defines.svh"

module emu_tb
    import emu_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;
    localparam int N_WORDS    = `EMU_FF_WORDS + `EMU_RAM_WORDS;

    logic                       clk;
    logic                       rst;
    logic                       s_axil_awvalid;
    logic                       s_axil_awready;
    logic [`EMU_ADDR_W-1:0]     s_axil_awaddr;
    logic                       s_axil_wvalid;
    logic                       s_axil_wready;
    logic [`EMU_DATA_W-1:0]     s_axil_wdata;
    logic [`EMU_DATA_W/8-1:0]   s_axil_wstrb;
    logic                       s_axil_bvalid;
    logic                       s_axil_bready;
    axil_resp_t                 s_axil_bresp;
    logic                       s_axil_arvalid;
    logic                       s_axil_arready;
    logic [`EMU_ADDR_W-1:0]     s_axil_araddr;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;
    logic [`EMU_DATA_W-1:0]     s_axil_rdata;
    axil_resp_t                 s_axil_rresp;
    logic                       dut_rst;
    logic [`EMU_TRIG_W-1:0]     dut_trig;
    logic [`EMU_TRIG_W-1:0]     trig_in;
    logic                       ff_clk_en;
    logic                       ram_clk_en;
    logic                       ff_se;
    logic [`EMU_SCAN_W-1:0]     ff_sdi;
    logic [`EMU_SCAN_W-1:0]     ff_sdo;
    logic                       ram_se;
    ckpt_dir_t                  ram_sd;
    logic [`EMU_SCAN_W-1:0]     ram_sdi;
    logic [`EMU_SCAN_W-1:0]     ram_sdo;
    logic [`EMU_SCAN_W-1:0]     ckpt_out_data;
    logic                       ckpt_out_valid;
    logic                       ckpt_out_last;
    logic                       ckpt_out_ready;
    logic [`EMU_SCAN_W-1:0]     ckpt_in_data;
    logic                       ckpt_in_valid;
    logic                       ckpt_in_ready;

    logic [15:0]                lfsr;
    // Expected chain contents with the flip-flop words first
    logic [`EMU_SCAN_W-1:0]     exp_words [N_WORDS];
    logic [`EMU_SCAN_W-1:0]     saved [N_WORDS];
    logic [`EMU_SCAN_W-1:0]     first_save [N_WORDS];

    int                         edge_count = 0;
    int                         resp_edge;

    emu_controller UUT (.*);

    emu_chain_model u_chain_model (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Rising edges seen so far
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit returned
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic axil_write(input logic [`EMU_ADDR_W-1:0] addr,
                              input logic [`EMU_DATA_W-1:0] data,
                              input logic [`EMU_DATA_W/8-1:0] strb,
                              output axil_resp_t resp);
        int     t;
        logic   aw_done;
        logic   w_done;
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_wvalid  = 1'b1;
        t = 0;
        // Ready depends only on registered state and is stable here
        while (s_axil_awvalid || s_axil_wvalid) begin
            aw_done = s_axil_awvalid && s_axil_awready;
            w_done  = s_axil_wvalid && s_axil_wready;
            @(negedge clk);
            if (aw_done) begin
                s_axil_awvalid = 1'b0;
            end
            if (w_done) begin
                s_axil_wvalid = 1'b0;
            end
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout on the write address or write data channel");
            end
        end
        s_axil_bready = 1'b1;
        t = 0;
        while (!s_axil_bvalid) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout waiting for the write response");
            end
        end
        // Commit edge is the last posedge before bvalid shows
        resp_edge = edge_count;
        resp = s_axil_bresp;
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`EMU_ADDR_W-1:0] addr,
                             output logic [`EMU_DATA_W-1:0] data,
                             output axil_resp_t resp);
        int     t;
        logic   ar_done;
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        t = 0;
        while (s_axil_arvalid) begin
            ar_done = s_axil_arready;
            @(negedge clk);
            if (ar_done) begin
                s_axil_arvalid = 1'b0;
            end
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout on the read address channel");
            end
        end
        s_axil_rready = 1'b1;
        t = 0;
        while (!s_axil_rvalid) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout waiting for read data");
            end
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic reg_write(input logic [`EMU_ADDR_W-1:0] addr,
                             input logic [`EMU_DATA_W-1:0] data);
        axil_resp_t resp;
        axil_write(addr, data, '1, resp);
        check_value("write response", resp, AXIL_OKAY);
    endtask

    task automatic reg_check(input logic [`EMU_ADDR_W-1:0] addr,
                             input logic [`EMU_DATA_W-1:0] exp, input string what);
        logic [`EMU_DATA_W-1:0] data;
        axil_resp_t             resp;
        axil_read(addr, data, resp);
        check_value(what, data, exp);
    endtask

    task automatic read_cycle(output logic [63:0] cycle);
        logic [`EMU_DATA_W-1:0] lo;
        logic [`EMU_DATA_W-1:0] hi;
        axil_resp_t             resp;
        axil_read(`EMU_CYCLE_LO, lo, resp);
        axil_read(`EMU_CYCLE_HI, hi, resp);
        cycle = {hi, lo};
    endtask

    // Register polling with its own limit
    task automatic wait_for_bit(input logic [`EMU_ADDR_W-1:0] addr, input int bit_idx,
                                input logic value, input string what);
        logic [`EMU_DATA_W-1:0] data;
        axil_resp_t             resp;
        int                     t;
        t = 0;
        axil_read(addr, data, resp);
        while (data[bit_idx] !== value) begin
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run({"Timeout waiting for ", what});
            end
            axil_read(addr, data, resp);
        end
    endtask

    task automatic load_chains();
        int idx;
        int t;
        reg_write(`EMU_CKPT_CTRL, 32'h3);
        idx = 0;
        t = 0;
        while (idx < N_WORDS) begin
            ckpt_in_valid = rand_bits(1) != 0;
            ckpt_in_data  = exp_words[idx];
            if (ckpt_in_valid && ckpt_in_ready) begin
                idx++;
            end
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout while streaming checkpoint load data");
            end
        end
        ckpt_in_valid = 1'b0;
        // Running drops on the edge of the last transfer
        reg_check(`EMU_CKPT_STAT, 32'h0, "CKPT_STAT after load");
    endtask

    task automatic save_chains();
        int idx;
        int t;
        reg_write(`EMU_CKPT_CTRL, 32'h1);
        idx = 0;
        t = 0;
        while (idx < N_WORDS) begin
            ckpt_out_ready = rand_bits(1) != 0;
            if (ckpt_out_valid && ckpt_out_ready) begin
                saved[idx] = ckpt_out_data;
                check_value($sformatf("ckpt_out_last on word %0d", idx),
                            ckpt_out_last, idx == N_WORDS - 1);
                idx++;
            end
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                stop_run("Timeout while collecting checkpoint save data");
            end
        end
        ckpt_out_ready = 1'b0;
        reg_check(`EMU_CKPT_STAT, 32'h0, "CKPT_STAT after save");
    endtask

    task automatic compare_saved();
        for (int i = 0; i < N_WORDS; i++) begin
            check_value($sformatf("saved word %0d", i), saved[i], exp_words[i]);
        end
    endtask

    initial begin
        logic [`EMU_DATA_W-1:0] rdata;
        axil_resp_t             resp;
        logic [63:0]            value;
        logic [63:0]            step_n;
        logic [63:0]            trig;
        logic [63:0]            cyc_start;
        logic [63:0]            cyc_end;
        int                     run_start;
        int                     run_len;

        lfsr           = 16'd62463;
        rst            = 1'b1;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_bready  = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr  = '0;
        s_axil_rready  = 1'b0;
        trig_in        = '0;
        ckpt_out_ready = 1'b0;
        ckpt_in_data   = '0;
        ckpt_in_valid  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values and plain register access
        reg_check(`EMU_STAT, 32'h3, "STAT after reset");
        check_value("dut_rst after reset", dut_rst, 1'b1);
        reg_check(`EMU_CKPT_SIZE, 8 * N_WORDS, "CKPT_SIZE");
        value = rand_bits(64);
        reg_write(`EMU_CYCLE_LO, value[31:0]);
        reg_check(`EMU_CYCLE_LO, value[31:0], "CYCLE_LO readback");
        reg_write(`EMU_CYCLE_HI, value[63:32]);
        reg_check(`EMU_CYCLE_HI, value[63:32], "CYCLE_HI readback");
        value = rand_bits(32);
        reg_write(`EMU_STEP, value[31:0]);
        reg_check(`EMU_STEP, value[31:0], "STEP readback");
        reg_write(`EMU_STEP, 32'h0);
        reg_write(`EMU_STAT, 32'h2);
        reg_check(`EMU_STAT, 32'h2, "STAT running in DUT reset");
        reg_write(`EMU_STAT, 32'h1);
        reg_check(`EMU_STAT, 32'h1, "STAT paused out of DUT reset");
        check_value("dut_rst out of DUT reset", dut_rst, 1'b0);

        // Partial strobe and unmapped address
        axil_write(`EMU_STEP, 32'hFFFF_FFFF, 4'b0111, resp);
        check_value("partial strobe response", resp, AXIL_SLVERR);
        reg_check(`EMU_STEP, 32'h0, "STEP after partial strobe");
        axil_read(12'h100, rdata, resp);
        check_value("unmapped read data", rdata, 0);
        check_value("unmapped read response", resp, AXIL_OKAY);

        // Load then save round trip
        for (int i = 0; i < N_WORDS; i++) begin
            exp_words[i] = rand_bits(64);
        end
        load_chains();
        save_chains();
        compare_saved();

        // Second save must match the first
        for (int i = 0; i < N_WORDS; i++) begin
            first_save[i] = saved[i];
        end
        save_chains();
        for (int i = 0; i < N_WORDS; i++) begin
            check_value($sformatf("repeated save word %0d", i), saved[i], first_save[i]);
        end

        // Step run
        cyc_start = rand_bits(64);
        step_n    = rand_bits(6) + 1;
        reg_write(`EMU_CYCLE_LO, cyc_start[31:0]);
        reg_write(`EMU_CYCLE_HI, cyc_start[63:32]);
        reg_write(`EMU_STEP, step_n[31:0]);
        reg_write(`EMU_STAT, 32'h0);
        wait_for_bit(`EMU_STAT, 0, 1'b1, "the step count to pause the DUT");
        read_cycle(cyc_end);
        check_value("cycle count after step", cyc_end, cyc_start + step_n);
        reg_check(`EMU_STAT, 32'h8000_0001, "STAT after step");
        for (int i = 0; i < `EMU_FF_WORDS; i++) begin
            exp_words[i] = exp_words[i] + step_n;
        end
        save_chains();
        compare_saved();

        // Trigger stops a free run
        cyc_start = cyc_start + step_n;
        trig = rand_bits(32);
        if (trig == 0) begin
            trig = 1;
        end
        reg_write(`EMU_STAT, 32'h0);
        run_start = resp_edge;
        repeat (rand_bits(4) + 1) @(negedge clk);
        trig_in = trig[31:0];
        @(negedge clk);
        trig_in = '0;
        // Each posedge after the STAT commit up to the trigger edge is a run cycle
        run_len = edge_count - run_start;
        wait_for_bit(`EMU_STAT, 0, 1'b1, "the trigger to pause the DUT");
        reg_check(`EMU_TRIG_STAT, trig[31:0], "TRIG_STAT");
        reg_check(`EMU_STAT, 32'h1, "STAT after trigger");
        read_cycle(cyc_end);
        check_value("cycle count after trigger", cyc_end, cyc_start + run_len);
        for (int i = 0; i < `EMU_FF_WORDS; i++) begin
            exp_words[i] = exp_words[i] + run_len;
        end
        save_chains();
        compare_saved();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
rtl/emu_pkg.sv
rtl/emu_csr_slave.sv
rtl/emu_run_ctrl.sv
rtl/emu_ckpt_seq.sv
rtl/emu_controller.sv
bench/emu_chain_model.sv
bench/emu_tb.sv
